// ==== design/alu.sv ====
//----------------------------------------------------------------------
// ALU
// Single-cycle arithmetic, logic, shift and compare operations,
// plus the compare flag used by the branch unit
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  ex_pkg::fu_op_e operator_i,
    input  ex_pkg::xlen_t  operand_a_i,
    input  ex_pkg::xlen_t  operand_b_i,
    output ex_pkg::xlen_t  result_o,
    output logic           branch_cmp_o
);

    logic       is_less;
    logic       is_equal;
    logic [4:0] shamt;

    // Unsigned compare shared by SLTU and the branch compares
    assign is_less  = operand_a_i < operand_b_i;
    assign is_equal = operand_a_i == operand_b_i;
    assign shamt    = operand_b_i[4:0];

    always_comb begin
        result_o     = '0;
        branch_cmp_o = 1'b0;

        case (operator_i)
            ex_pkg::OP_ADD:  result_o = operand_a_i + operand_b_i;
            ex_pkg::OP_SUB:  result_o = operand_a_i - operand_b_i;
            ex_pkg::OP_AND:  result_o = operand_a_i & operand_b_i;
            ex_pkg::OP_OR:   result_o = operand_a_i | operand_b_i;
            ex_pkg::OP_XOR:  result_o = operand_a_i ^ operand_b_i;
            ex_pkg::OP_SLL:  result_o = operand_a_i << shamt;
            ex_pkg::OP_SRL:  result_o = operand_a_i >> shamt;
            ex_pkg::OP_SLTU: result_o = ex_pkg::xlen_t'(is_less);

            // Compares only drive the flag, result stays zero
            ex_pkg::OP_EQ:   branch_cmp_o = is_equal;
            ex_pkg::OP_NE:   branch_cmp_o = ~is_equal;
            ex_pkg::OP_LTU:  branch_cmp_o = is_less;
            ex_pkg::OP_GEU:  branch_cmp_o = ~is_less;

            default: begin
                result_o     = '0;
                branch_cmp_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/branch_unit.sv ====
//----------------------------------------------------------------------
// Branch unit
// Resolves conditional branches from the ALU compare flag, checks
// the prediction and forms the link address
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  logic          branch_valid_i,
    input  ex_pkg::xlen_t pc_i,
    input  ex_pkg::xlen_t imm_i,
    input  logic          is_compressed_i,
    input  logic          branch_cmp_i,
    input  logic          predict_taken_i,
    input  ex_pkg::xlen_t predict_target_i,
    output ex_pkg::xlen_t link_addr_o,
    output ex_pkg::xlen_t resolved_target_o,
    output logic          resolved_taken_o,
    output logic          mispredict_o,
    output logic          resolve_branch_o
);

    ex_pkg::xlen_t pc_step;
    ex_pkg::xlen_t jump_target;
    logic          taken;
    logic          target_wrong;

    // Next sequential PC, compressed instructions are 2 bytes
    assign pc_step     = is_compressed_i ? ex_pkg::xlen_t'(2) : ex_pkg::xlen_t'(4);
    assign link_addr_o = pc_i + pc_step;
    assign jump_target = pc_i + imm_i;

    assign taken             = branch_valid_i & branch_cmp_i;
    assign resolved_taken_o  = taken;
    assign resolved_target_o = taken ? jump_target : link_addr_o;
    assign resolve_branch_o  = branch_valid_i;

    // Wrong direction, or right direction but wrong target
    assign target_wrong = taken & (jump_target != predict_target_i);
    assign mispredict_o = branch_valid_i & ((taken != predict_taken_i) | target_wrong);

endmodule

`default_nettype wire

// ==== design/csr_buffer.sv ====
//----------------------------------------------------------------------
// CSR buffer
// Holds the address of one outstanding CSR instruction and stalls
// issue until it commits or the pipeline is flushed
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module csr_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              csr_valid_i,
    input  logic              csr_commit_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    output ex_pkg::xlen_t     csr_result_o,
    output logic              csr_ready_o,
    output ex_pkg::csr_addr_t csr_addr_o
);

    logic              full_q;
    ex_pkg::csr_addr_t addr_q;

    // Operand a is written back unchanged
    assign csr_result_o = operand_a_i;
    assign csr_ready_o  = ~full_q | csr_commit_i;
    assign csr_addr_o   = addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end else if (csr_commit_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= operand_b_i[`EX_CSR_ADDR_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_pkg.sv ====
//----------------------------------------------------------------------
// Execute stage package
// Data types and the functional-unit opcode encoding
//----------------------------------------------------------------------
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]          xlen_t;
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_t;

    // Opcodes for the fixed-latency units
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLTU,
        // Branch compares
        OP_EQ,
        OP_NE,
        OP_LTU,
        OP_GEU,
        OP_CSRRW,
        OP_MUL,
        OP_MULHU
    } fu_op_e;

endpackage

`default_nettype wire

// ==== design/ex_settings.svh ====
//----------------------------------------------------------------------
// Execute stage settings
// Widths and latency shared by the fixed-latency units
//----------------------------------------------------------------------
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data and address width
`define EX_XLEN 32

// Scoreboard transaction ID width
`define EX_TRANS_ID_BITS 3

// CSR address width
`define EX_CSR_ADDR_BITS 12

// Cycles from multiplier issue to result
`define EX_MULT_LATENCY 1

`endif

// ==== design/ex_stage.sv ====
//----------------------------------------------------------------------
// Execute stage, fixed-latency units
// ALU, branch unit, CSR buffer and multiplier behind one issue port
// and one shared write-back port
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    // Issue port
    input  ex_pkg::fu_op_e    operator_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::xlen_t     imm_i,
    input  ex_pkg::trans_id_t trans_id_i,
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  logic              mult_valid_i,
    // Branch context
    input  ex_pkg::xlen_t     pc_i,
    input  logic              is_compressed_i,
    input  logic              predict_taken_i,
    input  ex_pkg::xlen_t     predict_target_i,
    input  logic              csr_commit_i,
    // Write-back
    output logic              flu_valid_o,
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o,
    output logic              flu_ready_o,
    output ex_pkg::csr_addr_t csr_addr_o,
    // Branch resolution
    output logic              resolve_branch_o,
    output logic              resolved_taken_o,
    output ex_pkg::xlen_t     resolved_target_o,
    output logic              mispredict_o
);

    ex_pkg::xlen_t     alu_result;
    ex_pkg::xlen_t     link_addr;
    ex_pkg::xlen_t     csr_result;
    ex_pkg::xlen_t     mult_result;
    ex_pkg::trans_id_t mult_trans_id;
    logic              branch_cmp;
    logic              mult_valid;

    alu i_alu (
        .operator_i   (operator_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .result_o     (alu_result),
        .branch_cmp_o (branch_cmp)
    );

    branch_unit i_branch_unit (
        .branch_valid_i    (branch_valid_i),
        .pc_i              (pc_i),
        .imm_i             (imm_i),
        .is_compressed_i   (is_compressed_i),
        .branch_cmp_i      (branch_cmp),
        .predict_taken_i   (predict_taken_i),
        .predict_target_i  (predict_target_i),
        .link_addr_o       (link_addr),
        .resolved_target_o (resolved_target_o),
        .resolved_taken_o  (resolved_taken_o),
        .mispredict_o      (mispredict_o),
        .resolve_branch_o  (resolve_branch_o)
    );

    // Only the CSR buffer can stall issue
    csr_buffer i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .csr_result_o (csr_result),
        .csr_ready_o  (flu_ready_o),
        .csr_addr_o   (csr_addr_o)
    );

    multiplier i_multiplier (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .trans_id_i      (trans_id_i),
        .mult_valid_o    (mult_valid),
        .result_o        (mult_result),
        .mult_trans_id_o (mult_trans_id)
    );

    wb_arbiter i_wb_arbiter (
        .alu_valid_i     (alu_valid_i),
        .branch_valid_i  (branch_valid_i),
        .csr_valid_i     (csr_valid_i),
        .mult_valid_i    (mult_valid),
        .alu_result_i    (alu_result),
        .csr_result_i    (csr_result),
        .mult_result_i   (mult_result),
        .link_addr_i     (link_addr),
        .trans_id_i      (trans_id_i),
        .mult_trans_id_i (mult_trans_id),
        .flu_valid_o     (flu_valid_o),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o)
    );

endmodule

`default_nettype wire

// ==== design/multiplier.sv ====
//----------------------------------------------------------------------
// Multiplier
// One-stage unsigned multiplier returning the low or high half of
// the product, with its transaction ID carried alongside
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module multiplier (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              mult_valid_i,
    input  ex_pkg::fu_op_e    operator_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::trans_id_t trans_id_i,
    output logic              mult_valid_o,
    output ex_pkg::xlen_t     result_o,
    output ex_pkg::trans_id_t mult_trans_id_o
);

    logic [2*`EX_XLEN-1:0] product;
    ex_pkg::xlen_t         result_d;
    ex_pkg::xlen_t         result_q;
    ex_pkg::trans_id_t     trans_id_q;
    logic                  valid_q;

    assign product  = operand_a_i * operand_b_i;
    // High half for MULHU, low half otherwise
    assign result_d = (operator_i == ex_pkg::OP_MULHU) ? product[2*`EX_XLEN-1:`EX_XLEN]
                                                       : product[`EX_XLEN-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= trans_id_i;
    end

    // A flush also kills the result leaving this cycle
    assign mult_valid_o    = valid_q & ~flush_i;
    assign result_o        = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

`default_nettype wire

// ==== design/wb_arbiter.sv ====
//----------------------------------------------------------------------
// Write-back arbiter
// Fixed-priority select of the shared write-back port
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter (
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  logic              mult_valid_i,
    input  ex_pkg::xlen_t     alu_result_i,
    input  ex_pkg::xlen_t     csr_result_i,
    input  ex_pkg::xlen_t     mult_result_i,
    input  ex_pkg::xlen_t     link_addr_i,
    input  ex_pkg::trans_id_t trans_id_i,
    input  ex_pkg::trans_id_t mult_trans_id_i,
    output logic              flu_valid_o,
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o
);

    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    //------------------------------------------------------------------
    // Result select: ALU, CSR, multiplier, branch link by default
    //------------------------------------------------------------------
    always_comb begin
        flu_result_o   = link_addr_i;
        flu_trans_id_o = trans_id_i;

        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i) begin
            // Multiply finishes later, so use its own ID
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

endmodule

`default_nettype wire

// ==== dv/ex_stage_tb.sv ====
//----------------------------------------------------------------------
// Execute stage testbench
// Drives ALU, branch, CSR and multiply traffic and checks write-back,
// branch resolution and the CSR stall against a small model
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module ex_stage_tb;

    localparam int PERIOD          = 40;
    localparam int ALU_ROUNDS      = 4;
    localparam int BRANCH_ROUNDS   = 8;
    localparam int CSR_ROUNDS      = 3;
    localparam int MULT_PAIRS      = 4;
    // Flush tests add one multiply and one CSR issue
    localparam int NUM_ISSUES      = 8 * ALU_ROUNDS + 4 * BRANCH_ROUNDS + CSR_ROUNDS
                                     + 2 * MULT_PAIRS + 2;
    localparam int WATCHDOG_CYCLES = NUM_ISSUES * 4 + 200;

    localparam ex_pkg::fu_op_e ALU_OPS [8] = '{ex_pkg::OP_ADD, ex_pkg::OP_SUB,
        ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_SLL,
        ex_pkg::OP_SRL, ex_pkg::OP_SLTU};
    localparam ex_pkg::fu_op_e CMP_OPS [4] = '{ex_pkg::OP_EQ, ex_pkg::OP_NE,
        ex_pkg::OP_LTU, ex_pkg::OP_GEU};

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              flush_i;
    ex_pkg::fu_op_e    operator_i;
    ex_pkg::xlen_t     operand_a_i;
    ex_pkg::xlen_t     operand_b_i;
    ex_pkg::xlen_t     imm_i;
    ex_pkg::trans_id_t trans_id_i;
    logic              alu_valid_i;
    logic              branch_valid_i;
    logic              csr_valid_i;
    logic              mult_valid_i;
    ex_pkg::xlen_t     pc_i;
    logic              is_compressed_i;
    logic              predict_taken_i;
    ex_pkg::xlen_t     predict_target_i;
    logic              csr_commit_i;
    logic              flu_valid_o;
    ex_pkg::xlen_t     flu_result_o;
    ex_pkg::trans_id_t flu_trans_id_o;
    logic              flu_ready_o;
    ex_pkg::csr_addr_t csr_addr_o;
    logic              resolve_branch_o;
    logic              resolved_taken_o;
    ex_pkg::xlen_t     resolved_target_o;
    logic              mispredict_o;

    integer seed;
    int     error_count;
    int     errors_at_start;
    int     tests_passed;
    int     tests_failed;

    ex_stage i_ex_stage (.*);

    always #(PERIOD / 2) clk_i = ~clk_i;

    //------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------
    function automatic ex_pkg::xlen_t model_alu(ex_pkg::fu_op_e op, ex_pkg::xlen_t a,
                                                ex_pkg::xlen_t b);
        case (op)
            ex_pkg::OP_ADD:  return a + b;
            ex_pkg::OP_SUB:  return a - b;
            ex_pkg::OP_AND:  return a & b;
            ex_pkg::OP_OR:   return a | b;
            ex_pkg::OP_XOR:  return a ^ b;
            ex_pkg::OP_SLL:  return a << b[4:0];
            ex_pkg::OP_SRL:  return a >> b[4:0];
            ex_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:         return '0;
        endcase
    endfunction

    function automatic logic model_cmp(ex_pkg::fu_op_e op, ex_pkg::xlen_t a, ex_pkg::xlen_t b);
        case (op)
            ex_pkg::OP_EQ:  return a == b;
            ex_pkg::OP_NE:  return a != b;
            ex_pkg::OP_LTU: return a < b;
            default:        return a >= b;
        endcase
    endfunction

    function automatic ex_pkg::xlen_t model_mul(logic high, ex_pkg::xlen_t a, ex_pkg::xlen_t b);
        logic [63:0] p;
        p = {32'd0, a} * {32'd0, b};
        return high ? p[63:32] : p[31:0];
    endfunction

    //------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------
    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t ns %s: expected %h, actual %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic idle_inputs();
        flush_i          = 1'b0;
        operator_i       = ex_pkg::OP_ADD;
        operand_a_i      = '0;
        operand_b_i      = '0;
        imm_i            = '0;
        trans_id_i       = '0;
        alu_valid_i      = 1'b0;
        branch_valid_i   = 1'b0;
        csr_valid_i      = 1'b0;
        mult_valid_i     = 1'b0;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        predict_taken_i  = 1'b0;
        predict_target_i = '0;
        csr_commit_i     = 1'b0;
    endtask

    // Issue only while the stage accepts
    task automatic wait_ready();
        while (!flu_ready_o) @(negedge clk_i);
    endtask

    task automatic drive_issue(ex_pkg::fu_op_e op, ex_pkg::xlen_t a, ex_pkg::xlen_t b,
                               ex_pkg::trans_id_t id);
        wait_ready();
        operator_i  = op;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = id;
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("[TEST] %s passed", name);
        end else begin
            tests_failed++;
            $display("[TEST] %s failed with %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // Write-back check in the middle of the low clock phase
    task automatic check_wb(ex_pkg::xlen_t result, ex_pkg::trans_id_t id);
        #(PERIOD / 4);
        expect_value("flu_valid_o", 32'd1, 32'(flu_valid_o));
        expect_value("flu_result_o", result, flu_result_o);
        expect_value("flu_trans_id_o", 32'(id), 32'(flu_trans_id_o));
    endtask

    //------------------------------------------------------------------
    // Tests
    //------------------------------------------------------------------
    task automatic run_alu_ops();
        ex_pkg::xlen_t     a;
        ex_pkg::xlen_t     b;
        ex_pkg::trans_id_t id;
        int                r;
        int                i;
        for (r = 0; r < ALU_ROUNDS; r++) begin
            for (i = 0; i < 8; i++) begin
                a  = $random(seed);
                b  = $random(seed);
                id = ex_pkg::trans_id_t'($random(seed));
                drive_issue(ALU_OPS[i], a, b, id);
                alu_valid_i = 1'b1;
                check_wb(model_alu(ALU_OPS[i], a, b), id);
                @(negedge clk_i);
                idle_inputs();
            end
        end
    endtask

    task automatic run_branches();
        ex_pkg::xlen_t     a;
        ex_pkg::xlen_t     b;
        ex_pkg::xlen_t     pc;
        ex_pkg::xlen_t     link;
        ex_pkg::xlen_t     target;
        ex_pkg::trans_id_t id;
        logic              taken;
        logic              miss;
        int                r;
        int                i;
        for (r = 0; r < BRANCH_ROUNDS; r++) begin
            for (i = 0; i < 4; i++) begin
                a  = $random(seed);
                // Equal operands half of the time so EQ and NE both resolve taken
                b  = ($random(seed) & 1) ? a : $random(seed);
                id = ex_pkg::trans_id_t'($random(seed));
                pc = $random(seed) & 32'hffff_fffe;
                drive_issue(CMP_OPS[i], a, b, id);
                branch_valid_i   = 1'b1;
                pc_i             = pc;
                imm_i            = $random(seed) & 32'h0000_0ffe;
                is_compressed_i  = $random(seed) & 1;
                predict_taken_i  = $random(seed) & 1;
                predict_target_i = ($random(seed) & 1) ? pc + imm_i : $random(seed);
                taken  = model_cmp(CMP_OPS[i], a, b);
                link   = pc + (is_compressed_i ? 32'd2 : 32'd4);
                target = taken ? pc + imm_i : link;
                miss   = (taken != predict_taken_i) || (taken && target != predict_target_i);
                check_wb(link, id);
                expect_value("resolve_branch_o", 32'd1, 32'(resolve_branch_o));
                expect_value("resolved_taken_o", 32'(taken), 32'(resolved_taken_o));
                expect_value("resolved_target_o", target, resolved_target_o);
                expect_value("mispredict_o", 32'(miss), 32'(mispredict_o));
                @(negedge clk_i);
                idle_inputs();
            end
        end
    endtask

    task automatic run_csr_commits();
        ex_pkg::xlen_t     a;
        ex_pkg::xlen_t     b;
        ex_pkg::trans_id_t id;
        int                r;
        for (r = 0; r < CSR_ROUNDS; r++) begin
            a  = $random(seed);
            b  = $random(seed);
            id = ex_pkg::trans_id_t'($random(seed));
            drive_issue(ex_pkg::OP_CSRRW, a, b, id);
            csr_valid_i = 1'b1;
            check_wb(a, id);
            @(negedge clk_i);
            idle_inputs();
            repeat (3) begin
                #(PERIOD / 4);
                expect_value("flu_ready_o", 32'd0, 32'(flu_ready_o));
                expect_value("csr_addr_o", 32'(b[`EX_CSR_ADDR_BITS-1:0]), 32'(csr_addr_o));
                @(negedge clk_i);
            end
            csr_commit_i = 1'b1;
            @(negedge clk_i);
            idle_inputs();
            #(PERIOD / 4);
            expect_value("flu_ready_o", 32'd1, 32'(flu_ready_o));
            @(negedge clk_i);
        end
    endtask

    task automatic run_mult_pairs();
        ex_pkg::xlen_t     a [2];
        ex_pkg::xlen_t     b [2];
        ex_pkg::trans_id_t id [2];
        int                p;
        int                c;
        int                k;
        for (p = 0; p < MULT_PAIRS; p++) begin
            for (c = 0; c < 2 + `EX_MULT_LATENCY; c++) begin
                idle_inputs();
                if (c < 2) begin
                    a[c]  = $random(seed);
                    b[c]  = $random(seed);
                    id[c] = ex_pkg::trans_id_t'($random(seed));
                    drive_issue(c == 0 ? ex_pkg::OP_MUL : ex_pkg::OP_MULHU, a[c], b[c], id[c]);
                    mult_valid_i = 1'b1;
                end
                k = c - `EX_MULT_LATENCY;
                if (k >= 0 && k < 2) begin
                    check_wb(model_mul(k == 1, a[k], b[k]), id[k]);
                end else begin
                    #(PERIOD / 4);
                    expect_value("flu_valid_o", 32'd0, 32'(flu_valid_o));
                end
                @(negedge clk_i);
            end
            idle_inputs();
        end
    endtask

    task automatic run_flushes();
        int c;
        drive_issue(ex_pkg::OP_MUL, $random(seed), $random(seed), 3'd5);
        mult_valid_i = 1'b1;
        @(negedge clk_i);
        idle_inputs();
        flush_i = 1'b1;
        // The killed multiply must not reach write-back
        for (c = 1; c <= `EX_MULT_LATENCY; c++) begin
            #(PERIOD / 4);
            expect_value("flu_valid_o", 32'd0, 32'(flu_valid_o));
            @(negedge clk_i);
            idle_inputs();
        end
        drive_issue(ex_pkg::OP_CSRRW, $random(seed), $random(seed), 3'd2);
        csr_valid_i = 1'b1;
        @(negedge clk_i);
        idle_inputs();
        flush_i = 1'b1;
        @(negedge clk_i);
        idle_inputs();
        #(PERIOD / 4);
        expect_value("flu_ready_o", 32'd1, 32'(flu_ready_o));
        @(negedge clk_i);
    endtask

    //------------------------------------------------------------------
    // Protocol properties
    //------------------------------------------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csr_commit_i || flush_i) |=> flu_ready_o)
    else begin
        $display("[ERROR] %0t ns flu_ready_o: expected 1, actual %b", $time,
                 $sampled(flu_ready_o));
        error_count++;
    end

    // Resolution is reported in a branch issue cycle and in no other
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        resolve_branch_o == branch_valid_i)
    else begin
        $display("[ERROR] %0t ns resolve_branch_o: expected %b, actual %b", $time,
                 $sampled(branch_valid_i), $sampled(resolve_branch_o));
        error_count++;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles before the tests completed",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed            = 32'hc975;
        error_count     = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        idle_inputs();
        rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        #(PERIOD / 4);
        expect_value("flu_valid_o", 32'd0, 32'(flu_valid_o));
        expect_value("resolve_branch_o", 32'd0, 32'(resolve_branch_o));
        expect_value("flu_ready_o", 32'd1, 32'(flu_ready_o));
        @(negedge clk_i);
        finish_test("reset");
        run_alu_ops();
        finish_test("alu");
        run_branches();
        finish_test("branch");
        run_csr_commits();
        finish_test("csr_buffer");
        run_mult_pairs();
        finish_test("multiplier");
        run_flushes();
        finish_test("flush");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execute-stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module ex_stage_tb \
    && { out=$(./obj_dir/Vex_stage_tb); echo "$out"; } \
    && grep -qx "Test OK" <<< "$out" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+design
design/ex_pkg.sv
design/alu.sv
design/branch_unit.sv
design/csr_buffer.sv
design/multiplier.sv
design/wb_arbiter.sv
design/ex_stage.sv
dv/ex_stage_tb.sv
